// ==== hdl/tcSettings_settings.svh ====
// Data and address widths, register map, counter top and prescaler taps
`ifndef TC_SETTINGS_SVH
`define TC_SETTINGS_SVH

// --------------------
// Bus and counter widths
`define TC_DATA_W      8
`define TC_ADR_W       3

// --------------------
// Register map
`define TC_ADR_CTRL0   3'd0
`define TC_ADR_CNT0    3'd1
`define TC_ADR_CMP0    3'd2
`define TC_ADR_CTRL2   3'd3
`define TC_ADR_CNT2    3'd4
`define TC_ADR_CMP2    3'd5
`define TC_ADR_MASK    3'd6
`define TC_ADR_FLAGS   3'd7

`define TC_TOP         8'hFF      // Overflow and PWM turn-around value

// --------------------
// Prescaler, taps given as number of low counter bits
`define TC_PRE_W       10
`define TC_TAP8        3
`define TC_TAP32       5
`define TC_TAP64       6
`define TC_TAP128      7
`define TC_TAP256      8
`define TC_TAP1024     10

`endif

// ==== hdl/tcPkg.sv ====
// Timer types: control register union, tick, write and status structs, flag bit positions
`include "tcSettings_settings.svh"

package tcPkg;

   // --------------------
   // Control register
   typedef struct packed {
      logic       reserved;   // Always reads zero
      logic       pwm;        // Phase-correct PWM
      logic [1:0] com;        // Compare output mode
      logic       ctc;        // Clear on compare match
      logic [2:0] cs;         // Clock select
   } tcCtrlFieldsS;

   // Bus side sees a byte, channel side the fields
   typedef union packed {
      logic [7:0]   raw;
      tcCtrlFieldsS f;
   } tcCtrlU;

   // --------------------
   // Prescaler outputs
   typedef struct packed {
      logic div8;
      logic div32;
      logic div64;
      logic div128;
      logic div256;
      logic div1024;
   } tcTicksS;

   // Write strobes from the bus to one channel
   typedef struct packed {
      logic                  wrCtrl;
      logic                  wrCount;
      logic                  wrCompare;
      logic [`TC_DATA_W-1:0] data;
   } tcChanWrS;

   // Channel state back to the bus
   typedef struct packed {
      tcCtrlU                ctrl;
      logic [`TC_DATA_W-1:0] count;
      logic [`TC_DATA_W-1:0] cmpRead;
      logic                  ovfEvt;     // Overflow event, one cycle
      logic                  cmpEvt;     // Compare match event, one cycle
   } tcChanStatS;

   // --------------------
   // Mask and flag register layout
   localparam int unsigned TOV0_BIT = 0;
   localparam int unsigned OCF0_BIT = 1;
   localparam int unsigned TOV2_BIT = 6;
   localparam int unsigned OCF2_BIT = 7;

endpackage

// ==== hdl/tcPrescaler.sv ====
// Free-running prescaler producing single-cycle divide ticks
`timescale 1ns/1ps
`include "tcSettings_settings.svh"

module tcPrescaler
(
   input  logic           cp2,
   input  logic           ireset,
   output tcPkg::tcTicksS ticks
);

   logic [`TC_PRE_W-1:0] preCnt;

   // --------------------
   // Divider counter
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         preCnt <= '0;
      end
      else
      begin
         preCnt <= preCnt + 1'b1;
      end
   end

   // Tick registers, a pulse follows each all-ones pattern of the tap bits
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         ticks <= '0;
      end
      else
      begin
         ticks.div8    <= ~ticks.div8    & (&preCnt[`TC_TAP8-1:0]);
         ticks.div32   <= ~ticks.div32   & (&preCnt[`TC_TAP32-1:0]);
         ticks.div64   <= ~ticks.div64   & (&preCnt[`TC_TAP64-1:0]);
         ticks.div128  <= ~ticks.div128  & (&preCnt[`TC_TAP128-1:0]);
         ticks.div256  <= ~ticks.div256  & (&preCnt[`TC_TAP256-1:0]);
         ticks.div1024 <= ~ticks.div1024 & (&preCnt[`TC_TAP1024-1:0]);
      end
   end

endmodule

// ==== hdl/tcChannel.sv ====
// One 8-bit timer/counter with control, count, compare buffer and compare output
`timescale 1ns/1ps
`include "tcSettings_settings.svh"

module tcChannel
(
   input  logic              cp2,
   input  logic              ireset,
   input  tcPkg::tcTicksS    ticks,
   input  tcPkg::tcChanWrS   wr,
   output tcPkg::tcChanStatS stat,
   output logic              oc
);

   import tcPkg::*;

   tcCtrlU                ctrl;
   logic [`TC_DATA_W-1:0] count;
   logic [`TC_DATA_W-1:0] cmpAct;     // Value used for matching
   logic [`TC_DATA_W-1:0] cmpBuf;     // PWM double buffer
   logic                  dir;        // 0 up, 1 down
   logic                  dirNext;
   logic                  tick;
   logic                  wrFl;       // Compare still blocked after a count write
   logic                  cmpBlk;
   logic                  match;
   logic                  atTop;

   // --------------------
   // Clock select
   always_comb
   begin
      case (ctrl.f.cs)
         3'd0:    tick = 1'b0;          // Stopped
         3'd1:    tick = 1'b1;
         3'd2:    tick = ticks.div8;
         3'd3:    tick = ticks.div32;
         3'd4:    tick = ticks.div64;
         3'd5:    tick = ticks.div128;
         3'd6:    tick = ticks.div256;
         default: tick = ticks.div1024;
      endcase
   end

   assign atTop   = (count == `TC_TOP);
   assign match   = (count == cmpAct);
   assign cmpBlk  = wr.wrCount | wrFl;
   // Reverse at either end of the PWM ramp
   assign dirNext = dir ? (count != '0) : atTop;

   // Control register, bit 7 kept at zero
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         ctrl <= '0;
      end
      else if (wr.wrCtrl)
      begin
         ctrl.raw <= wr.data & 8'h7F;
      end
   end

   // --------------------
   // Counter and direction
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         count <= '0;
         dir   <= 1'b0;
      end
      else if (wr.wrCount)
      begin
         count <= wr.data;
      end
      else if (!ctrl.f.pwm)
      begin
         if (ctrl.f.ctc && match)
            count <= '0;                       // CTC clear, not tick gated
         else if (tick)
            count <= count + 1'b1;
      end
      else if (tick)
      begin
         dir   <= dirNext;
         count <= dirNext ? count - 1'b1 : count + 1'b1;
      end
   end

   // Compare value and its buffer
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         cmpAct <= '0;
         cmpBuf <= '0;
      end
      else
      begin
         if (wr.wrCompare)
            cmpBuf <= wr.data;
         if (!ctrl.f.pwm)
         begin
            if (wr.wrCompare)
               cmpAct <= wr.data;
         end
         else if (tick && atTop)
         begin
            cmpAct <= cmpBuf;                  // Update at top of the ramp
         end
      end
   end

   // Write block, set by a write in an idle cycle and dropped on the next idle one
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         wrFl <= 1'b0;
      else if (!wrFl)
         wrFl <= wr.wrCount & ~tick;
      else if (!tick)
         wrFl <= 1'b0;
   end

   // --------------------
   // Compare output
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         oc <= 1'b0;
      end
      else if (tick)
      begin
         if (!ctrl.f.pwm)
         begin
            if (match && !cmpBlk && ctrl.f.com == 2'b01)
               oc <= ~oc;                      // Toggle
         end
         else if (ctrl.f.com[1])
         begin
            // com[0] selects the inverted form
            if (atTop)
            begin
               if (cmpBuf == '0)
                  oc <= ctrl.f.com[0];         // Always off
               else if (cmpBuf == `TC_TOP)
                  oc <= ~ctrl.f.com[0];        // Always on
            end
            else if (match && cmpAct != '0)
            begin
               oc <= dir ^ ctrl.f.com[0];      // Clear going up, set going down
            end
         end
      end
   end

   // Status back to the bus
   always_comb
   begin
      stat.ctrl    = ctrl;
      stat.count   = count;
      stat.cmpRead = ctrl.f.pwm ? cmpBuf : cmpAct;
      stat.ovfEvt  = tick & (ctrl.f.pwm ? (count == '0) : atTop);
      stat.cmpEvt  = tick & match & ~cmpBlk;
   end

endmodule

// ==== hdl/tcRegBus.sv ====
// Wishbone slave with address decode, mask and flag registers, read mux and IRQs
`timescale 1ns/1ps
`include "tcSettings_settings.svh"

module tcRegBus
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  logic                  wbCyc,
   input  logic                  wbStb,
   input  logic                  wbWe,
   input  logic [`TC_ADR_W-1:0]  wbAdr,
   input  logic [`TC_DATA_W-1:0] wbDatI,
   output logic [`TC_DATA_W-1:0] wbDatO,
   output logic                  wbAck,
   output tcPkg::tcChanWrS       wr0,
   output tcPkg::tcChanWrS       wr2,
   input  tcPkg::tcChanStatS     stat0,
   input  tcPkg::tcChanStatS     stat2,
   input  logic                  tc0OvfAck,
   input  logic                  tc0CmpAck,
   input  logic                  tc2OvfAck,
   input  logic                  tc2CmpAck,
   output logic                  tc0OvfIrq,
   output logic                  tc0CmpIrq,
   output logic                  tc2OvfIrq,
   output logic                  tc2CmpIrq
);

   import tcPkg::*;

   logic                  accept;
   logic                  wrAcc;
   logic [`TC_DATA_W-1:0] mask;
   logic [`TC_DATA_W-1:0] flags;
   logic [`TC_DATA_W-1:0] flagSet;
   logic [`TC_DATA_W-1:0] flagClr;
   logic [`TC_DATA_W-1:0] rdData;

   // --------------------
   // Handshake, one ack per access
   assign accept = wbCyc & wbStb & ~wbAck;
   assign wrAcc  = accept & wbWe;

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         wbAck <= 1'b0;
      else
         wbAck <= accept;
   end

   // Channel write strobes
   always_comb
   begin
      wr0.wrCtrl    = wrAcc & (wbAdr == `TC_ADR_CTRL0);
      wr0.wrCount   = wrAcc & (wbAdr == `TC_ADR_CNT0);
      wr0.wrCompare = wrAcc & (wbAdr == `TC_ADR_CMP0);
      wr0.data      = wbDatI;
      wr2.wrCtrl    = wrAcc & (wbAdr == `TC_ADR_CTRL2);
      wr2.wrCount   = wrAcc & (wbAdr == `TC_ADR_CNT2);
      wr2.wrCompare = wrAcc & (wbAdr == `TC_ADR_CMP2);
      wr2.data      = wbDatI;
   end

   // --------------------
   // Mask and flags
   always_comb
   begin
      flagSet           = '0;
      flagSet[TOV0_BIT] = stat0.ovfEvt;
      flagSet[OCF0_BIT] = stat0.cmpEvt;
      flagSet[TOV2_BIT] = stat2.ovfEvt;
      flagSet[OCF2_BIT] = stat2.cmpEvt;
      flagClr           = (wrAcc && wbAdr == `TC_ADR_FLAGS) ? wbDatI : '0;  // Write one to clear
      flagClr[TOV0_BIT] = flagClr[TOV0_BIT] | tc0OvfAck;
      flagClr[OCF0_BIT] = flagClr[OCF0_BIT] | tc0CmpAck;
      flagClr[TOV2_BIT] = flagClr[TOV2_BIT] | tc2OvfAck;
      flagClr[OCF2_BIT] = flagClr[OCF2_BIT] | tc2CmpAck;
   end

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         mask  <= '0;
         flags <= '0;
      end
      else
      begin
         if (wrAcc && wbAdr == `TC_ADR_MASK)
            mask <= wbDatI;
         flags <= (flags & ~flagClr) | flagSet;   // Set wins
      end
   end

   assign tc0OvfIrq = flags[TOV0_BIT] & mask[TOV0_BIT];
   assign tc0CmpIrq = flags[OCF0_BIT] & mask[OCF0_BIT];
   assign tc2OvfIrq = flags[TOV2_BIT] & mask[TOV2_BIT];
   assign tc2CmpIrq = flags[OCF2_BIT] & mask[OCF2_BIT];

   // --------------------
   // Read path
   always_comb
   begin
      case (wbAdr)
         `TC_ADR_CTRL0: rdData = stat0.ctrl.raw;
         `TC_ADR_CNT0:  rdData = stat0.count;
         `TC_ADR_CMP0:  rdData = stat0.cmpRead;
         `TC_ADR_CTRL2: rdData = stat2.ctrl.raw;
         `TC_ADR_CNT2:  rdData = stat2.count;
         `TC_ADR_CMP2:  rdData = stat2.cmpRead;
         `TC_ADR_MASK:  rdData = mask;
         default:       rdData = flags;
      endcase
   end

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         wbDatO <= '0;
      else if (accept && !wbWe)
         wbDatO <= rdData;
   end

endmodule

// ==== hdl/timerCounter.sv ====
// Timer peripheral top: prescaler, two timer channels and the Wishbone register bus
`timescale 1ns/1ps
`include "tcSettings_settings.svh"

module timerCounter
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  logic                  wbCyc,
   input  logic                  wbStb,
   input  logic                  wbWe,
   input  logic [`TC_ADR_W-1:0]  wbAdr,
   input  logic [`TC_DATA_W-1:0] wbDatI,
   output logic [`TC_DATA_W-1:0] wbDatO,
   output logic                  wbAck,
   output logic                  oc0,
   output logic                  oc2,
   output logic                  tc0OvfIrq,
   output logic                  tc0CmpIrq,
   output logic                  tc2OvfIrq,
   output logic                  tc2CmpIrq,
   input  logic                  tc0OvfAck,
   input  logic                  tc0CmpAck,
   input  logic                  tc2OvfAck,
   input  logic                  tc2CmpAck
);

   import tcPkg::*;

   tcTicksS    ticks;     // Shared by both channels
   tcChanWrS   wr0;
   tcChanWrS   wr2;
   tcChanStatS stat0;
   tcChanStatS stat2;

   tcPrescaler prescaler (.cp2, .ireset, .ticks);

   tcChannel chan0 (.cp2, .ireset, .ticks, .wr(wr0), .stat(stat0), .oc(oc0));
   tcChannel chan2 (.cp2, .ireset, .ticks, .wr(wr2), .stat(stat2), .oc(oc2));

   tcRegBus regBus
   (
      .cp2,
      .ireset,
      .wbCyc,
      .wbStb,
      .wbWe,
      .wbAdr,
      .wbDatI,
      .wbDatO,
      .wbAck,
      .wr0,
      .wr2,
      .stat0,
      .stat2,
      .tc0OvfAck,
      .tc0CmpAck,
      .tc2OvfAck,
      .tc2CmpAck,
      .tc0OvfIrq,
      .tc0CmpIrq,
      .tc2OvfIrq,
      .tc2CmpIrq
   );

endmodule

// ==== dv/tb_timerCounter.sv ====
// Directed timer testbench with clock, reset, Wishbone tasks, check task, LFSR and five tests
`timescale 1ns/1ps
`include "tcSettings_settings.svh"

module tb_timerCounter;

   import tcPkg::*;

   localparam int ACK_LIMIT = 16;

   logic                  cp2 = 1'b0;
   logic                  ireset;
   logic                  wbCyc;
   logic                  wbStb;
   logic                  wbWe;
   logic [`TC_ADR_W-1:0]  wbAdr;
   logic [`TC_DATA_W-1:0] wbDatI;
   logic [`TC_DATA_W-1:0] wbDatO;
   logic                  wbAck;
   logic                  oc0;
   logic                  oc2;
   logic                  tc0OvfIrq;
   logic                  tc0CmpIrq;
   logic                  tc2OvfIrq;
   logic                  tc2CmpIrq;
   logic                  tc0OvfAck;
   logic                  tc0CmpAck;
   logic                  tc2OvfAck;
   logic                  tc2CmpAck;
   logic [15:0]           lfsr = 16'd746;
   int                    cycles = 0;      // Time base for edge spacing

   timerCounter dut (.*);

   always #20 cp2 = ~cp2;

   always @(posedge cp2)
      cycles <= cycles + 1;

   // --------------------
   // Reporting
   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected)
         abortRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
   endtask

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic randByte(output logic [7:0] b);
      b = '0;
      for (int i = 0; i < 8; i++)
      begin
         lfsr = lfsrNext(lfsr);
         b    = {b[6:0], lfsr[0]};
      end
   endtask

   // --------------------
   // Wishbone master
   task automatic waitAck(input string what);
      int n = 0;
      @(negedge cp2);
      while (!wbAck && n < ACK_LIMIT)
      begin
         @(negedge cp2);
         n++;
      end
      if (!wbAck)
         abortRun({"Timeout waiting for wbAck on a ", what});
   endtask

   task automatic wbWrite(input logic [`TC_ADR_W-1:0] adr, input logic [7:0] data);
      @(posedge cp2);
      wbCyc  <= 1'b1;
      wbStb  <= 1'b1;
      wbWe   <= 1'b1;
      wbAdr  <= adr;
      wbDatI <= data;
      waitAck("write");
      @(posedge cp2);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe  <= 1'b0;
   endtask

   task automatic wbRead(input logic [`TC_ADR_W-1:0] adr, output logic [7:0] data);
      @(posedge cp2);
      wbCyc <= 1'b1;
      wbStb <= 1'b1;
      wbWe  <= 1'b0;
      wbAdr <= adr;
      waitAck("read");
      data = wbDatO;                         // Stable at the falling edge
      @(posedge cp2);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
   endtask

   // --------------------
   // Helpers
   task automatic stopAll();
      wbWrite(`TC_ADR_CTRL0, 8'h00);
      wbWrite(`TC_ADR_CTRL2, 8'h00);
      wbWrite(`TC_ADR_MASK, 8'h00);
      wbWrite(`TC_ADR_FLAGS, 8'hFF);         // Clear every flag
   endtask

   task automatic waitFlag(input int bitPos);
      logic [7:0] v;
      int         n = 0;
      wbRead(`TC_ADR_FLAGS, v);
      while (!v[bitPos] && n < 200)
      begin
         wbRead(`TC_ADR_FLAGS, v);
         n++;
      end
      if (!v[bitPos])
         abortRun($sformatf("Timeout waiting for flag bit %0d to set", bitPos));
   endtask

   task automatic waitOc0(input logic level, output int at);
      int n = 0;
      @(negedge cp2);
      while (oc0 !== level && n < 600)
      begin
         @(negedge cp2);
         n++;
      end
      if (oc0 !== level)
         abortRun("Timeout waiting for oc0 to change");
      at = cycles;
   endtask

   task automatic waitOc2Toggle();
      logic old;
      int   n = 0;
      old = oc2;
      @(negedge cp2);
      while (oc2 === old && n < 600)
      begin
         @(negedge cp2);
         n++;
      end
      if (oc2 === old)
         abortRun("Timeout waiting for oc2 to toggle");
   endtask

   task automatic countHigh(input int len, output int high);
      high = 0;
      repeat (len)
      begin
         @(negedge cp2);
         if (oc0)
            high++;
      end
   endtask

   task automatic writeReadBack(input logic [`TC_ADR_W-1:0] adr, input string name);
      logic [7:0] r;
      logic [7:0] v;
      randByte(r);
      wbWrite(adr, r);
      wbRead(adr, v);
      check(name, 32'(v), 32'(r));
   endtask

   // --------------------
   // Tests
   task automatic testResetReadback();
      logic [7:0] v;
      logic [7:0] r;
      check("wbAck", 32'(wbAck), 0);
      check("oc0", 32'(oc0), 0);
      check("oc2", 32'(oc2), 0);
      check("irqs", 32'({tc0OvfIrq, tc0CmpIrq, tc2OvfIrq, tc2CmpIrq}), 0);
      for (int a = 0; a < 8; a++)
      begin
         wbRead(3'(a), v);
         check($sformatf("register %0d", a), 32'(v), 0);
      end
      writeReadBack(`TC_ADR_MASK, "mask");
      writeReadBack(`TC_ADR_CNT0, "count0");
      writeReadBack(`TC_ADR_CMP0, "compare0");
      writeReadBack(`TC_ADR_CNT2, "count2");
      writeReadBack(`TC_ADR_CMP2, "compare2");
      randByte(r);
      r = (r | 8'h80) & 8'hB8;               // Reserved bit set, pwm and cs clear
      wbWrite(`TC_ADR_CTRL0, r);
      wbRead(`TC_ADR_CTRL0, v);
      check("ctrl0", 32'(v), 32'({1'b0, r[6:0]}));
      wbWrite(`TC_ADR_CTRL2, 8'hC0);
      wbRead(`TC_ADR_CTRL2, v);
      check("ctrl2", 32'(v), 32'h40);
      stopAll();
   endtask

   task automatic testOverflow();
      logic [7:0] v;
      wbWrite(`TC_ADR_CNT0, 8'hF0);
      wbWrite(`TC_ADR_MASK, 8'h01 << TOV0_BIT);
      wbWrite(`TC_ADR_CTRL0, 8'h01);         // cs 1
      waitFlag(TOV0_BIT);
      @(negedge cp2);
      check("tc0OvfIrq", 32'(tc0OvfIrq), 1);
      wbWrite(`TC_ADR_CTRL0, 8'h00);
      wbWrite(`TC_ADR_FLAGS, 8'h01 << TOV0_BIT);
      wbRead(`TC_ADR_FLAGS, v);
      check("flags TOV0 after write", 32'(v[TOV0_BIT]), 0);
      @(negedge cp2);
      check("tc0OvfIrq after write", 32'(tc0OvfIrq), 0);
      // Second overflow is gated by the mask and cleared by ack
      wbWrite(`TC_ADR_CNT0, 8'hF0);
      wbWrite(`TC_ADR_CTRL0, 8'h01);
      waitFlag(TOV0_BIT);
      wbWrite(`TC_ADR_CTRL0, 8'h00);
      wbWrite(`TC_ADR_MASK, 8'h00);
      @(negedge cp2);
      check("tc0OvfIrq masked", 32'(tc0OvfIrq), 0);
      wbWrite(`TC_ADR_MASK, 8'h01 << TOV0_BIT);
      @(negedge cp2);
      check("tc0OvfIrq unmasked", 32'(tc0OvfIrq), 1);
      @(posedge cp2);
      tc0OvfAck <= 1'b1;
      @(posedge cp2);
      tc0OvfAck <= 1'b0;
      wbRead(`TC_ADR_FLAGS, v);
      check("flags TOV0 after ack", 32'(v[TOV0_BIT]), 0);
      @(negedge cp2);
      check("tc0OvfIrq after ack", 32'(tc0OvfIrq), 0);
      stopAll();
   endtask

   task automatic testCtcToggle();
      logic [7:0] v;
      int         t1;
      int         t2;
      int         t3;
      wbWrite(`TC_ADR_CMP0, 8'h10);
      wbWrite(`TC_ADR_CNT0, 8'h00);
      wbWrite(`TC_ADR_CTRL0, 8'h19);         // CTC, com 01, cs 1
      repeat (20)
      begin
         wbRead(`TC_ADR_CNT0, v);
         check("count0 at most compare", 32'(v <= 8'h10), 1);
      end
      waitOc0(~oc0, t1);
      waitOc0(~oc0, t2);
      waitOc0(~oc0, t3);
      check("oc0 edge spacing", t2 - t1, 17);
      check("oc0 edge spacing", t3 - t2, 17);
      wbRead(`TC_ADR_FLAGS, v);
      check("flags OCF0", 32'(v[OCF0_BIT]), 1);
      stopAll();
   endtask

   task automatic testPwm();
      logic [7:0] v;
      int         high;
      int         tFall;
      int         tRise;
      wbWrite(`TC_ADR_CMP0, 8'h40);
      wbWrite(`TC_ADR_CNT0, 8'h00);
      wbWrite(`TC_ADR_CTRL0, 8'h61);         // PWM, com 10, cs 1
      repeat (600) @(posedge cp2);
      countHigh(510, high);
      check("oc0 high cycles", high, 128);
      wbWrite(`TC_ADR_CTRL0, 8'h71);         // Inverted
      repeat (600) @(posedge cp2);
      countHigh(510, high);
      check("oc0 low cycles", 510 - high, 128);
      // New compare lands at the next top only
      waitOc0(1'b1, tRise);
      waitOc0(1'b0, tFall);
      wbWrite(`TC_ADR_CMP0, 8'h80);
      wbRead(`TC_ADR_CMP0, v);
      check("compare0 buffer", 32'(v), 32'h80);
      waitOc0(1'b1, tRise);
      check("oc0 low pulse before top", tRise - tFall, 128);
      waitOc0(1'b0, tFall);
      waitOc0(1'b1, tRise);
      check("oc0 low pulse after top", tRise - tFall, 256);
      wbWrite(`TC_ADR_CTRL0, 8'h61);
      wbWrite(`TC_ADR_CMP0, 8'h00);
      repeat (600) @(posedge cp2);
      countHigh(510, high);
      check("oc0 high cycles, compare 00", high, 0);
      wbWrite(`TC_ADR_CMP0, 8'hFF);
      repeat (600) @(posedge cp2);
      countHigh(510, high);
      check("oc0 high cycles, compare FF", high, 510);
      stopAll();
   endtask

   task automatic testChannel2();
      logic [7:0] c0a;
      logic [7:0] c0b;
      logic [7:0] c2a;
      logic [7:0] c2b;
      logic [7:0] d;
      logic [7:0] v;
      wbWrite(`TC_ADR_CNT2, 8'h00);
      wbWrite(`TC_ADR_CTRL2, 8'h02);         // Clock / 8
      wbRead(`TC_ADR_CNT0, c0a);
      wbRead(`TC_ADR_CNT2, c2a);
      repeat (800) @(posedge cp2);
      wbRead(`TC_ADR_CNT2, c2b);
      wbRead(`TC_ADR_CNT0, c0b);
      d = c2b - c2a;
      check("count2 advance near 100", 32'(d >= 8'd99 && d <= 8'd101), 1);
      check("count0 stopped", 32'(c0b), 32'(c0a));
      wbWrite(`TC_ADR_CMP2, 8'h20);
      wbWrite(`TC_ADR_MASK, (8'h01 << TOV2_BIT) | (8'h01 << OCF2_BIT));
      wbWrite(`TC_ADR_CTRL2, 8'h01);
      waitFlag(TOV2_BIT);
      waitFlag(OCF2_BIT);
      wbWrite(`TC_ADR_CTRL2, 8'h00);
      wbRead(`TC_ADR_FLAGS, v);
      check("flags", 32'(v), 32'((8'h01 << TOV2_BIT) | (8'h01 << OCF2_BIT)));
      @(negedge cp2);
      check("tc2 irqs", 32'({tc2OvfIrq, tc2CmpIrq}), 32'h3);
      check("tc0 irqs", 32'({tc0OvfIrq, tc0CmpIrq}), 0);
      // Both channel 2 flags cleared by their acks
      @(posedge cp2);
      tc2OvfAck <= 1'b1;
      tc2CmpAck <= 1'b1;
      @(posedge cp2);
      tc2OvfAck <= 1'b0;
      tc2CmpAck <= 1'b0;
      wbRead(`TC_ADR_FLAGS, v);
      check("flags after tc2 acks", 32'(v), 0);
      @(negedge cp2);
      check("tc2 irqs after ack", 32'({tc2OvfIrq, tc2CmpIrq}), 0);
      wbWrite(`TC_ADR_CTRL2, 8'h19);         // CTC, com 01, cs 1
      waitOc2Toggle();
      waitOc2Toggle();
      stopAll();
   endtask

   // --------------------
   // Sequence
   initial
   begin
      ireset    <= 1'b0;
      wbCyc     <= 1'b0;
      wbStb     <= 1'b0;
      wbWe      <= 1'b0;
      wbAdr     <= '0;
      wbDatI    <= '0;
      tc0OvfAck <= 1'b0;
      tc0CmpAck <= 1'b0;
      tc2OvfAck <= 1'b0;
      tc2CmpAck <= 1'b0;
      repeat (2) @(posedge cp2);
      ireset <= 1'b1;
      @(negedge cp2);
      testResetReadback();
      testOverflow();
      testCtcToggle();
      testPwm();
      testChannel2();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/tcPkg.sv
hdl/tcPrescaler.sv
hdl/tcChannel.sv
hdl/tcRegBus.sv
hdl/timerCounter.sv
dv/tb_timerCounter.sv

// ==== run.sh ====
#!/bin/sh
# Build the timer testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary -f list.f --top-module tb_timerCounter -o tbSim \
   || { echo "Build failed"; exit 1; }
./obj_dir/tbSim > sim.log 2>&1 \
   || echo "Simulator exited with an error, CHECKS FAILED" >> sim.log
grep -q "CHECKS FAILED" sim.log \
   && { echo "Simulation failed, see sim.log"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }
